// ==== verilog/dps_pkg.sv ====
// Shared constants and types for the debug-port subsystem.
// Import into any module that needs pin positions, JTAG codes or the FSM enums.
package dps_pkg;

  // Shared debug pins and the GPIO bank
  localparam int DpsWidth  = 8;
  localparam int GpioWidth = 16;

  // Bit positions on the shared pins, bits 5 and 7 are not used here
  localparam int DpsTckSck   = 0;
  localparam int DpsTdiMosi  = 1;
  localparam int DpsTdoMiso  = 2;
  localparam int DpsTmsCsb   = 3;
  localparam int DpsTrstN    = 4;
  localparam int DpsJtagSpiN = 6;

  // Input synchronizer depth
  localparam int SyncStages = 2;

  // JTAG instruction register and codes
  localparam int                 IrWidth     = 4;
  localparam logic [31:0]        IdcodeValue = 32'h04F5_484D;
  localparam logic [IrWidth-1:0] IrIdcode    = 4'b0001;
  localparam logic [IrWidth-1:0] IrBypass    = 4'b1111;
  localparam logic [IrWidth-1:0] IrCapture   = 4'b0101;

  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle,
    SelectDrScan, CaptureDr, ShiftDr, Exit1Dr, PauseDr, Exit2Dr, UpdateDr,
    SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_e;

  // First byte of an SPI frame
  typedef enum logic [7:0] {
    SpiWrGpio = 8'h02,
    SpiRdGpio = 8'h03
  } spi_op_e;

endpackage

// ==== verilog/dps_pin_mux.sv ====
// Front end of the shared debug pins. Latches the JTAG/SPI strap during
// reset, synchronizes the pins into clk_i and turns the clock pin into
// rise/fall strobes for the selected side. Also drives the shared TDO/MISO pin.
`timescale 1ns/1ps

module dps_pin_mux import dps_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [DpsWidth-1:0] dps_i,
  input  logic                tdo_i,
  input  logic                tdo_en_i,
  input  logic                miso_i,
  output logic                dps_o,
  output logic                jtag_mode_o,
  output logic                tck_rise_o,
  output logic                tck_fall_o,
  output logic                tms_o,
  output logic                tdi_o,
  output logic                trst_n_o,
  output logic                sck_rise_o,
  output logic                sck_fall_o,
  output logic                mosi_o,
  output logic                csb_o
);

  // Packed as {trst_n, tms/csb, tdi/mosi, tck/sck}
  logic [3:0] pins_raw;
  logic [3:0] sync_q [SyncStages];
  logic [3:0] pins_s;
  logic       jtag_mode_q;
  logic       clk_s_q;
  logic       rise_q;
  logic       fall_q;

  assign pins_raw = {dps_i[DpsTrstN], dps_i[DpsTmsCsb], dps_i[DpsTdiMosi], dps_i[DpsTckSck]};

  // Strap follows the pin while reset is low, then holds
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      jtag_mode_q <= dps_i[DpsJtagSpiN];
    end
  end

  // csb resets high so the SPI side starts idle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < SyncStages; i++) begin
        sync_q[i] <= 4'b0100;
      end
    end else begin
      sync_q[0] <= pins_raw;
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign pins_s = sync_q[SyncStages-1];

  // Edge register on the synchronized clock pin
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      clk_s_q <= 1'b0;
      rise_q  <= 1'b0;
      fall_q  <= 1'b0;
    end else begin
      clk_s_q <= pins_s[0];
      rise_q  <= pins_s[0] & ~clk_s_q;
      fall_q  <= ~pins_s[0] & clk_s_q;
    end
  end

  assign jtag_mode_o = jtag_mode_q;
  assign tck_rise_o  = rise_q & jtag_mode_q;
  assign tck_fall_o  = fall_q & jtag_mode_q;
  assign sck_rise_o  = rise_q & ~jtag_mode_q;
  assign sck_fall_o  = fall_q & ~jtag_mode_q;

  assign tdi_o  = pins_s[1];
  assign mosi_o = pins_s[1];
  assign tms_o  = pins_s[2];
  // Idle side is held quiet: TAP in reset in SPI mode, csb high in JTAG mode
  assign csb_o    = pins_s[2] | jtag_mode_q;
  assign trst_n_o = pins_s[3] & jtag_mode_q;

  assign dps_o = jtag_mode_q ? (tdo_i & tdo_en_i) : miso_i;

  rise_fall_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(tck_rise_o && tck_fall_o) && !(sck_rise_o && sck_fall_o));

  no_spi_in_jtag_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_mode_o |-> !(sck_rise_o || sck_fall_o));

endmodule

// ==== verilog/jtag_tap.sv ====
// Minimal JTAG TAP with IDCODE and BYPASS, clocked by clk_i.
// Moves on tck_rise strobes from the pin mux and drives TDO on tck_fall.
`timescale 1ns/1ps

module jtag_tap import dps_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic tck_rise_i,
  input  logic tck_fall_i,
  input  logic tms_i,
  input  logic tdi_i,
  input  logic trst_n_i,
  output logic tdo_o,
  output logic tdo_en_o
);

  tap_state_e         state_q;
  tap_state_e         state_d;
  logic [IrWidth-1:0] ir_q;
  logic [IrWidth-1:0] ir_shift_q;
  logic [31:0]        dr_shift_q;
  logic               idcode_sel;
  logic               tap_rst;
  logic               tdo_q;
  logic               tdo_en_q;

  assign tap_rst = !rst_n_i || !trst_n_i;

  // Standard 1149.1 state graph
  always_comb begin
    state_d = state_q;
    case (state_q)
      TestLogicReset: state_d = tms_i ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = tms_i ? SelectDrScan : RunTestIdle;
      SelectDrScan:   state_d = tms_i ? SelectIrScan : CaptureDr;
      CaptureDr:      state_d = tms_i ? Exit1Dr : ShiftDr;
      ShiftDr:        state_d = tms_i ? Exit1Dr : ShiftDr;
      Exit1Dr:        state_d = tms_i ? UpdateDr : PauseDr;
      PauseDr:        state_d = tms_i ? Exit2Dr : PauseDr;
      Exit2Dr:        state_d = tms_i ? UpdateDr : ShiftDr;
      UpdateDr:       state_d = tms_i ? SelectDrScan : RunTestIdle;
      SelectIrScan:   state_d = tms_i ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = tms_i ? Exit1Ir : ShiftIr;
      ShiftIr:        state_d = tms_i ? Exit1Ir : ShiftIr;
      Exit1Ir:        state_d = tms_i ? UpdateIr : PauseIr;
      PauseIr:        state_d = tms_i ? Exit2Ir : PauseIr;
      Exit2Ir:        state_d = tms_i ? UpdateIr : ShiftIr;
      UpdateIr:       state_d = tms_i ? SelectDrScan : RunTestIdle;
      default:        state_d = TestLogicReset;
    endcase
  end

  // Unknown instructions fall back to BYPASS
  always_comb begin
    case (ir_q)
      IrIdcode: idcode_sel = 1'b1;
      default:  idcode_sel = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (tap_rst) begin
      state_q <= TestLogicReset;
    end else if (tck_rise_i) begin
      state_q <= state_d;
    end
  end

  // IR goes back to IDCODE whenever the TAP sits in Test-Logic-Reset
  always_ff @(posedge clk_i) begin
    if (tap_rst || state_q == TestLogicReset) begin
      ir_q <= IrIdcode;
    end else if (tck_fall_i && state_q == UpdateIr) begin
      ir_q <= ir_shift_q;
    end
  end

  // Capture and shift LSB first
  always_ff @(posedge clk_i) begin
    if (tck_rise_i) begin
      case (state_q)
        CaptureIr: ir_shift_q <= IrCapture;
        ShiftIr:   ir_shift_q <= {tdi_i, ir_shift_q[IrWidth-1:1]};
        CaptureDr: dr_shift_q <= idcode_sel ? IdcodeValue : '0;
        ShiftDr: begin
          if (idcode_sel) begin
            dr_shift_q <= {tdi_i, dr_shift_q[31:1]};
          end else begin
            // Single-bit bypass register lives in bit 0
            dr_shift_q <= {31'b0, tdi_i};
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (tap_rst) begin
      tdo_q    <= 1'b0;
      tdo_en_q <= 1'b0;
    end else if (tck_fall_i) begin
      tdo_en_q <= (state_q == ShiftDr) || (state_q == ShiftIr);
      if (state_q == ShiftIr) begin
        tdo_q <= ir_shift_q[0];
      end else if (state_q == ShiftDr) begin
        tdo_q <= dr_shift_q[0];
      end else begin
        tdo_q <= 1'b0;
      end
    end
  end

  assign tdo_o    = tdo_q;
  assign tdo_en_o = tdo_en_q;

  state_known_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(state_q));

endmodule

// ==== verilog/spi_gpio_dev.sv ====
// SPI mode-0 device for the GPIO bank. Frames are an opcode byte plus
// 16 data bits MSB first: 0x02 writes gpio_o, 0x03 reads back gpio_i.
// Runs on sck strobes from the pin mux, csb high aborts a frame.
`timescale 1ns/1ps

module spi_gpio_dev import dps_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 sck_rise_i,
  input  logic                 sck_fall_i,
  input  logic                 mosi_i,
  input  logic                 csb_i,
  input  logic [GpioWidth-1:0] gpio_i,
  output logic                 miso_o,
  output logic [GpioWidth-1:0] gpio_o
);

  logic [4:0]           bit_cnt_q;
  logic [GpioWidth-1:0] rx_q;
  logic [GpioWidth-1:0] tx_q;
  logic [GpioWidth-1:0] gpio_q;
  logic [7:0]           op_byte;
  logic                 wr_op_q;
  logic                 rd_op_q;
  logic                 miso_q;
  logic                 op_done;
  logic                 frame_done;
  logic                 tx_window;

  // Opcode as it completes on the 8th rise
  assign op_byte    = {rx_q[6:0], mosi_i};
  assign op_done    = (bit_cnt_q == 5'd7);
  assign frame_done = (bit_cnt_q == 5'd23);
  // Falls after rises 8 to 23 carry read data
  assign tx_window  = (bit_cnt_q >= 5'd8) && (bit_cnt_q <= 5'd23);

  // Bit count saturates at 24, extra bits are ignored
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || csb_i) begin
      bit_cnt_q <= '0;
      wr_op_q   <= 1'b0;
      rd_op_q   <= 1'b0;
    end else if (sck_rise_i) begin
      if (bit_cnt_q != 5'd24) begin
        bit_cnt_q <= bit_cnt_q + 5'd1;
      end
      if (op_done) begin
        case (spi_op_e'(op_byte))
          SpiWrGpio: wr_op_q <= 1'b1;
          SpiRdGpio: rd_op_q <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sck_rise_i) begin
      rx_q <= {rx_q[GpioWidth-2:0], mosi_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_q <= '0;
    end else if (!csb_i && sck_rise_i && wr_op_q && frame_done) begin
      gpio_q <= {rx_q[GpioWidth-2:0], mosi_i};
    end
  end

  // Snapshot of the inputs right after the read opcode
  always_ff @(posedge clk_i) begin
    if (sck_rise_i && op_done && spi_op_e'(op_byte) == SpiRdGpio) begin
      tx_q <= gpio_i;
    end else if (sck_fall_i && tx_window) begin
      tx_q <= {tx_q[GpioWidth-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || csb_i) begin
      miso_q <= 1'b0;
    end else if (sck_fall_i) begin
      miso_q <= rd_op_q && tx_window && tx_q[GpioWidth-1];
    end
  end

  assign miso_o = miso_q;
  assign gpio_o = gpio_q;

  gpio_in_frame_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$stable(gpio_o) |-> !$past(csb_i));

endmodule

// ==== verilog/dps_chip_top.sv ====
// Debug-port subsystem top. Shared DPS pins feed either the JTAG TAP or
// the SPI GPIO device, chosen by the strap on dps bit 6 at reset.
`timescale 1ns/1ps

module dps_chip_top import dps_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [DpsWidth-1:0]  dps_i,
  output logic                 dps_o,
  input  logic [GpioWidth-1:0] gpio_i,
  output logic [GpioWidth-1:0] gpio_o
);

  logic tck_rise;
  logic tck_fall;
  logic tms;
  logic tdi;
  logic trst_n;
  logic sck_rise;
  logic sck_fall;
  logic mosi;
  logic csb;
  logic tdo;
  logic tdo_en;
  logic miso;

  dps_pin_mux u_pin_mux (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dps_i       (dps_i),
    .tdo_i       (tdo),
    .tdo_en_i    (tdo_en),
    .miso_i      (miso),
    .dps_o       (dps_o),
    .jtag_mode_o (),
    .tck_rise_o  (tck_rise),
    .tck_fall_o  (tck_fall),
    .tms_o       (tms),
    .tdi_o       (tdi),
    .trst_n_o    (trst_n),
    .sck_rise_o  (sck_rise),
    .sck_fall_o  (sck_fall),
    .mosi_o      (mosi),
    .csb_o       (csb)
  );

  jtag_tap u_jtag_tap (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .tck_rise_i (tck_rise),
    .tck_fall_i (tck_fall),
    .tms_i      (tms),
    .tdi_i      (tdi),
    .trst_n_i   (trst_n),
    .tdo_o      (tdo),
    .tdo_en_o   (tdo_en)
  );

  spi_gpio_dev u_spi_gpio (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sck_rise_i (sck_rise),
    .sck_fall_i (sck_fall),
    .mosi_i     (mosi),
    .csb_i      (csb),
    .gpio_i     (gpio_i),
    .miso_o     (miso),
    .gpio_o     (gpio_o)
  );

endmodule

// ==== bench/tb.sv ====
// Testbench for the debug-port subsystem top level.
// Bit-bangs JTAG scans and SPI GPIO frames on the shared pins,
// first with the strap high, then with it low after a new reset.
`timescale 1ns/1ps

module tb import dps_pkg::*;;

  localparam int HalfPeriod  = 8;
  localparam int EdgeTimeout = 6;
  localparam int ResetCycles = 5;
  localparam int GpioTimeout = 20;

  logic                 clk_i;
  logic                 rst_n_i;
  logic [DpsWidth-1:0]  dps_i;
  logic                 dps_o;
  logic [GpioWidth-1:0] gpio_i;
  logic [GpioWidth-1:0] gpio_o;

  int checks;
  int errors;
  bit jtag_phase;

  dps_chip_top dut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .dps_i   (dps_i),
    .dps_o   (dps_o),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Watchdog for the whole run
  initial begin
    repeat (50000) @(posedge clk_i);
    $display("Simulation timed out before the test sequence finished");
    $display("Checks failed");
    $finish;
  end

  // SPI side never sees strobes in JTAG mode, so the GPIO outputs stay at reset
  gpio_idle_in_jtag_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_phase |-> gpio_o == '0)
  else begin
    $display("[ERROR] gpio_idle_in_jtag: expected 0000, actual %h", gpio_o);
    errors = errors + 1;
  end

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks = checks + 1;
    assert (act === exp) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic apply_reset(input logic strap);
    tick();
    rst_n_i = 1'b0;
    // trst_n high, tms/csb high, tck/sck low
    dps_i = 8'h18;
    dps_i[DpsJtagSpiN] = strap;
    repeat (ResetCycles) tick();
    rst_n_i = 1'b1;
    repeat (HalfPeriod) tick();
  endtask

  // Moves the shared clock pin and waits for the matching strobe
  task automatic clock_half(input logic level);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    tick();
    dps_i[DpsTckSck] = level;
    while (!seen && n < EdgeTimeout) begin
      tick();
      n = n + 1;
      seen = level ? (dut.tck_rise || dut.sck_rise) : (dut.tck_fall || dut.sck_fall);
    end
    if (!seen) begin
      $display("Clock strobe did not appear within %0d cycles of the pin change", EdgeTimeout);
      errors = errors + 1;
    end
    repeat (HalfPeriod - n) tick();
  endtask

  // TDO is sampled before the rising edge, as a JTAG host does
  task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
    tick();
    tdo = dps_o;
    dps_i[DpsTmsCsb]  = tms;
    dps_i[DpsTdiMosi] = tdi;
    clock_half(1'b1);
    clock_half(1'b0);
  endtask

  // Shift phase LSB first, then Update and back to Run-Test/Idle
  task automatic shift_bits(input int len, input logic [31:0] din,
                            output logic [31:0] dout);
    logic bit_out;
    dout = '0;
    for (int k = 0; k < len; k++) begin
      jtag_clock(k == len - 1, din[k], bit_out);
      dout[k] = bit_out;
    end
    jtag_clock(1'b1, 1'b0, bit_out);
    jtag_clock(1'b0, 1'b0, bit_out);
  endtask

  task automatic scan_dr(input int len, input logic [31:0] din,
                         output logic [31:0] dout);
    logic bit_out;
    jtag_clock(1'b1, 1'b0, bit_out);
    jtag_clock(1'b0, 1'b0, bit_out);
    jtag_clock(1'b0, 1'b0, bit_out);
    shift_bits(len, din, dout);
  endtask

  task automatic scan_ir(input logic [IrWidth-1:0] din, output logic [31:0] dout);
    logic bit_out;
    jtag_clock(1'b1, 1'b0, bit_out);
    jtag_clock(1'b1, 1'b0, bit_out);
    jtag_clock(1'b0, 1'b0, bit_out);
    jtag_clock(1'b0, 1'b0, bit_out);
    shift_bits(IrWidth, {28'b0, din}, dout);
  endtask

  // One 24-bit mode-0 frame, MSB first, MISO sampled before each rise
  task automatic spi_xfer(input logic [23:0] tx, output logic [23:0] rx);
    tick();
    dps_i[DpsTmsCsb] = 1'b0;
    repeat (HalfPeriod) tick();
    for (int k = 23; k >= 0; k--) begin
      tick();
      rx[k] = dps_o;
      dps_i[DpsTdiMosi] = tx[k];
      clock_half(1'b1);
      clock_half(1'b0);
    end
    tick();
    dps_i[DpsTmsCsb] = 1'b1;
    repeat (HalfPeriod) tick();
  endtask

  task automatic wait_gpio(input logic [GpioWidth-1:0] exp);
    int n;
    n = 0;
    while (gpio_o !== exp && n < GpioTimeout) begin
      tick();
      n = n + 1;
    end
    if (gpio_o !== exp) begin
      $display("GPIO outputs did not take the written value within %0d cycles", GpioTimeout);
      errors = errors + 1;
    end
  endtask

  initial begin
    logic [31:0]          rnd;
    logic [31:0]          dout;
    logic [23:0]          frame_rx;
    logic [GpioWidth-1:0] pattern;
    logic [GpioWidth-1:0] wr_value;
    logic                 tdo_bit;

    void'($urandom(32'h2408));
    checks     = 0;
    errors     = 0;
    jtag_phase = 1'b0;
    rst_n_i    = 1'b0;
    dps_i      = 8'h18;
    gpio_i     = '0;

    // JTAG mode, DR scan straight after reset gives IDCODE
    apply_reset(1'b1);
    jtag_phase = 1'b1;
    jtag_clock(1'b0, 1'b0, tdo_bit);
    scan_dr(32, 32'h0, dout);
    check_value("idcode_after_reset", IdcodeValue, dout);

    scan_ir(IrBypass, dout);
    check_value("ir_capture", {28'b0, IrCapture}, dout);

    // Bypass adds one bit of delay, led by the captured zero
    rnd = $urandom();
    pattern = rnd[15:0];
    scan_dr(17, {16'b0, pattern}, dout);
    check_value("bypass_delay", {15'b0, pattern, 1'b0}, dout);

    tick();
    dps_i[DpsTrstN] = 1'b0;
    repeat (6) tick();
    dps_i[DpsTrstN] = 1'b1;
    repeat (HalfPeriod) tick();
    jtag_clock(1'b0, 1'b0, tdo_bit);
    scan_dr(32, 32'h0, dout);
    check_value("idcode_after_trst", IdcodeValue, dout);

    // Strap pin changes after reset are ignored
    tick();
    dps_i[DpsJtagSpiN] = 1'b0;
    repeat (HalfPeriod) tick();
    scan_dr(32, 32'h0, dout);
    check_value("idcode_strap_ignored", IdcodeValue, dout);

    // SPI mode
    jtag_phase = 1'b0;
    apply_reset(1'b0);
    check_value("gpio_after_reset", 32'h0, {16'b0, gpio_o});
    rnd = $urandom();
    wr_value = rnd[15:0];
    spi_xfer({SpiWrGpio, wr_value}, frame_rx);
    wait_gpio(wr_value);
    check_value("gpio_write", {16'b0, wr_value}, {16'b0, gpio_o});

    rnd = $urandom();
    tick();
    gpio_i = rnd[15:0];
    spi_xfer({SpiRdGpio, 16'h0}, frame_rx);
    check_value("gpio_read", {16'b0, gpio_i}, {16'b0, frame_rx[15:0]});

    rnd = $urandom();
    spi_xfer({8'h5A, rnd[15:0]}, frame_rx);
    repeat (HalfPeriod) tick();
    check_value("unknown_op_gpio", {16'b0, wr_value}, {16'b0, gpio_o});
    check_value("unknown_op_miso", 32'h0, {8'b0, frame_rx});

    $display("Summary: %0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== dps_chip.f ====
verilog/dps_pkg.sv
verilog/dps_pin_mux.sv
verilog/jtag_tap.sv
verilog/spi_gpio_dev.sv
verilog/dps_chip_top.sv
bench/tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the debug-port testbench with Verilator, runs it and scans the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb \
  -f dps_chip.f \
  -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without reported failures"
